// File: Makefile
TOP := tb_gpu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --timescale 1ns/10ps -Wno-fatal \
		--top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: source/compute_cluster.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module compute_cluster #(
    parameter int CLUSTER_ID = 0
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        start,
    output logic       busy,
    dcr_base_if.sink   dcr_base,
    mem_req_if.master  mem_req,
    mem_rsp_if.slave   mem_rsp
);
    import gpu_pkg::*;

    // first word of this cluster's slice
    localparam mem_addr_t slice_base = mem_addr_t'(CLUSTER_ID * `GPU_SLICE_LEN);
    localparam ctag_t     last_idx   = ctag_t'(`GPU_SLICE_LEN - 1);

    cluster_state_t state;
    ctag_t          idx;
    mem_data_t      sum_r;
    mem_addr_t      offset;

    logic req_fire;
    logic rsp_take;

    assign offset = slice_base + mem_addr_t'(idx);

    // request fields come straight from state, so they hold under stall
    assign mem_req.valid = (state == issue_rd) || (state == issue_wr);
    assign mem_req.rw    = (state == issue_wr);
    assign mem_req.addr  = (state == issue_wr) ? dcr_base.dst_base + offset
                                               : dcr_base.src_base + offset;
    assign mem_req.data  = sum_r;
    assign mem_req.tag   = idx;

    assign mem_rsp.ready = 1'b1;  // sink never stalls

    assign req_fire = mem_req.valid && mem_req.ready;
    assign rsp_take = (state == wait_rd) && mem_rsp.valid && mem_rsp.ready
                      && (mem_rsp.tag == idx);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
            idx   <= '0;
        end else begin
            case (state)
                idle, done: begin
                    if (start) begin
                        state <= issue_rd;
                        idx   <= '0;
                    end else begin
                        state <= idle;
                    end
                end
                issue_rd: begin
                    if (req_fire) begin
                        state <= wait_rd;
                    end
                end
                wait_rd: begin
                    if (rsp_take) begin
                        state <= issue_wr;
                    end
                end
                issue_wr: begin
                    if (req_fire) begin
                        if (idx == last_idx) begin
                            state <= done;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= issue_rd;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // read data plus addend, written back on the next request
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            sum_r <= mem_rsp.data + dcr_base.addend;
        end
    end

    assign busy = (state == issue_rd) || (state == wait_rd) || (state == issue_wr);

endmodule

`default_nettype wire

// File: source/dcr_data.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module dcr_data (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    dcr_wr_valid,
    input  wire gpu_pkg::dcr_addr_t dcr_wr_addr,
    input  wire gpu_pkg::mem_data_t dcr_wr_data,
    output logic                   dcr_wr_ready,
    input  wire                    busy,          // system busy
    dcr_base_if.source             dcr_base
);
    import gpu_pkg::*;

    mem_addr_t src_base_r;
    mem_addr_t dst_base_r;
    mem_data_t addend_r;

    logic wr_fire;

    assign dcr_wr_ready = !busy;  // locked during a run
    assign wr_fire      = dcr_wr_valid && dcr_wr_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src_base_r <= '0;
            dst_base_r <= '0;
            addend_r   <= '0;
        end else if (wr_fire) begin
            case (dcr_wr_addr)
                dcr_addr_t'(`GPU_DCR_SRC): src_base_r <= dcr_wr_data[`GPU_ADDR_W-1:0];
                dcr_addr_t'(`GPU_DCR_DST): dst_base_r <= dcr_wr_data[`GPU_ADDR_W-1:0];
                dcr_addr_t'(`GPU_DCR_ADD): addend_r   <= dcr_wr_data;
                default: ;                // unknown address, dropped
            endcase
        end
    end

    assign dcr_base.src_base = src_base_r;
    assign dcr_base.dst_base = dst_base_r;
    assign dcr_base.addend   = addend_r;

endmodule

`default_nettype wire

// File: source/gpu_consts.svh
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// cluster layout
`define GPU_NUM_CLUSTERS    2
`define GPU_SLICE_LEN       8   // words per cluster

// memory port widths
`define GPU_ADDR_W          16  // word address
`define GPU_DATA_W          32

// tags
`define GPU_CTAG_W          3   // element index within a slice
`define GPU_MTAG_W          4   // cluster select bit on top of ctag

// device configuration registers
`define GPU_DCR_ADDR_W      4
`define GPU_DCR_SRC         0   // source base
`define GPU_DCR_DST         1   // destination base
`define GPU_DCR_ADD         2   // addend

`endif

// File: source/gpu_ifs.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

// memory request channel
interface mem_req_if #(
    parameter int TAG_W = `GPU_CTAG_W
);
    import gpu_pkg::*;

    logic             valid;
    logic             rw;       // 1 = write
    mem_addr_t        addr;
    mem_data_t        data;
    logic [TAG_W-1:0] tag;
    logic             ready;

    modport master (
        output valid, rw, addr, data, tag,
        input  ready
    );

    modport slave (
        input  valid, rw, addr, data, tag,
        output ready
    );
endinterface

// read response channel
interface mem_rsp_if #(
    parameter int TAG_W = `GPU_CTAG_W
);
    import gpu_pkg::*;

    logic             valid;
    mem_data_t        data;
    logic [TAG_W-1:0] tag;
    logic             ready;

    modport master (
        output valid, data, tag,
        input  ready
    );

    modport slave (
        input  valid, data, tag,
        output ready
    );
endinterface

// base configuration seen by the clusters
interface dcr_base_if;
    import gpu_pkg::*;

    mem_addr_t src_base;
    mem_addr_t dst_base;
    mem_data_t addend;

    modport source (output src_base, dst_base, addend);
    modport sink (input src_base, dst_base, addend);
endinterface

`default_nettype wire

// File: source/gpu_pkg.sv
`default_nettype none

`include "gpu_consts.svh"

package gpu_pkg;

    // memory side
    typedef logic [`GPU_ADDR_W-1:0]     mem_addr_t;
    typedef logic [`GPU_DATA_W-1:0]     mem_data_t;

    typedef logic [`GPU_CTAG_W-1:0]     ctag_t;     // per cluster
    typedef logic [`GPU_MTAG_W-1:0]     mtag_t;     // after the mux

    typedef logic [`GPU_DCR_ADDR_W-1:0] dcr_addr_t;

    // cluster streaming FSM
    typedef enum logic [2:0] {
        idle,
        issue_rd,
        wait_rd,
        issue_wr,
        done
    } cluster_state_t;

endpackage

`default_nettype wire

// File: source/gpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module gpu_top (
    input  wire                     clk,
    input  wire                     arst_n,

    output logic                    mem_req_valid,
    output logic                    mem_req_rw,
    output gpu_pkg::mem_addr_t      mem_req_addr,
    output gpu_pkg::mem_data_t      mem_req_data,
    output gpu_pkg::mtag_t          mem_req_tag,
    input  wire                     mem_req_ready,

    input  wire                     mem_rsp_valid,
    input  wire gpu_pkg::mem_data_t mem_rsp_data,
    input  wire gpu_pkg::mtag_t     mem_rsp_tag,
    output logic                    mem_rsp_ready,

    input  wire                     dcr_wr_valid,
    input  wire gpu_pkg::dcr_addr_t dcr_wr_addr,
    input  wire gpu_pkg::mem_data_t dcr_wr_data,
    output logic                    dcr_wr_ready,

    input  wire                     start,
    output logic                    busy
);
    mem_req_if #(.TAG_W(`GPU_MTAG_W)) mem_req_bus ();
    mem_rsp_if #(.TAG_W(`GPU_MTAG_W)) mem_rsp_bus ();

    mem_req_if #(.TAG_W(`GPU_CTAG_W)) cl_req [`GPU_NUM_CLUSTERS] ();
    mem_rsp_if #(.TAG_W(`GPU_CTAG_W)) cl_rsp [`GPU_NUM_CLUSTERS] ();

    dcr_base_if dcr_base ();

    logic [`GPU_NUM_CLUSTERS-1:0] cluster_busy;
    logic                         start_go;

    assign mem_req_valid     = mem_req_bus.valid;
    assign mem_req_rw        = mem_req_bus.rw;
    assign mem_req_addr      = mem_req_bus.addr;
    assign mem_req_data      = mem_req_bus.data;
    assign mem_req_tag       = mem_req_bus.tag;
    assign mem_req_bus.ready = mem_req_ready;

    assign mem_rsp_bus.valid = mem_rsp_valid;
    assign mem_rsp_bus.data  = mem_rsp_data;
    assign mem_rsp_bus.tag   = mem_rsp_tag;
    assign mem_rsp_ready     = mem_rsp_bus.ready;

    assign start_go = start && !busy;  // no restart mid-run

    dcr_data u_dcr_data (
        .clk          (clk),
        .arst_n       (arst_n),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .dcr_wr_ready (dcr_wr_ready),
        .busy         (busy),
        .dcr_base     (dcr_base)
    );

    for (genvar i = 0; i < `GPU_NUM_CLUSTERS; i++) begin : g_cluster
        compute_cluster #(
            .CLUSTER_ID (i)
        ) u_cluster (
            .clk      (clk),
            .arst_n   (arst_n),
            .start    (start_go),
            .busy     (cluster_busy[i]),
            .dcr_base (dcr_base),
            .mem_req  (cl_req[i]),
            .mem_rsp  (cl_rsp[i])
        );
    end

    assign busy = |cluster_busy;

    mem_mux u_mem_mux (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_in  (cl_req),
        .rsp_in  (cl_rsp),
        .req_out (mem_req_bus),
        .rsp_out (mem_rsp_bus)
    );

endmodule

`default_nettype wire

// File: source/mem_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module mem_mux (
    input  wire       clk,
    input  wire       arst_n,
    mem_req_if.slave  req_in [`GPU_NUM_CLUSTERS],
    mem_rsp_if.master rsp_in [`GPU_NUM_CLUSTERS],
    mem_req_if.master req_out,
    mem_rsp_if.slave  rsp_out
);
    import gpu_pkg::*;

    localparam int n     = `GPU_NUM_CLUSTERS;
    localparam int sel_w = `GPU_MTAG_W - `GPU_CTAG_W;

    typedef logic [sel_w-1:0] sel_t;

    logic [n-1:0] req_valid;
    logic [n-1:0] req_rw;
    mem_addr_t    req_addr [n];
    mem_data_t    req_data [n];
    ctag_t        req_tag  [n];
    logic [n-1:0] rsp_ready;

    sel_t rr_ptr;      // highest priority next time
    sel_t pick_idx;
    sel_t grant_idx;
    sel_t hold_idx_r;
    sel_t rsp_sel;
    logic hold_r;      // stalled grant stays put
    logic req_fire;

    // flatten the interface arrays
    for (genvar i = 0; i < n; i++) begin : g_port
        assign req_valid[i] = req_in[i].valid;
        assign req_rw[i]    = req_in[i].rw;
        assign req_addr[i]  = req_in[i].addr;
        assign req_data[i]  = req_in[i].data;
        assign req_tag[i]   = req_in[i].tag;
        assign req_in[i].ready = req_out.ready && (grant_idx == sel_t'(i));

        assign rsp_in[i].valid = rsp_out.valid && (rsp_sel == sel_t'(i));
        assign rsp_in[i].data  = rsp_out.data;
        assign rsp_in[i].tag   = rsp_out.tag[`GPU_CTAG_W-1:0];
        assign rsp_ready[i]    = rsp_in[i].ready;
    end

    // round-robin search from rr_ptr
    always_comb begin
        sel_t cand;
        logic found;
        pick_idx = rr_ptr;
        found    = 1'b0;
        for (int k = 0; k < n; k++) begin
            cand = sel_t'((int'(rr_ptr) + k) % n);
            if (!found && req_valid[cand]) begin
                pick_idx = cand;
                found    = 1'b1;
            end
        end
    end

    assign grant_idx = hold_r ? hold_idx_r : pick_idx;

    assign req_out.valid = |req_valid;
    assign req_out.rw    = req_rw[grant_idx];
    assign req_out.addr  = req_addr[grant_idx];
    assign req_out.data  = req_data[grant_idx];
    assign req_out.tag   = {grant_idx, req_tag[grant_idx]};  // cluster id on top

    assign req_fire = req_out.valid && req_out.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr     <= '0;
            hold_r     <= 1'b0;
            hold_idx_r <= '0;
        end else begin
            hold_r     <= req_out.valid && !req_out.ready;
            hold_idx_r <= grant_idx;
            if (req_fire) begin
                rr_ptr <= sel_t'((int'(grant_idx) + 1) % n);
            end
        end
    end

    // response goes back to the cluster named in the tag
    assign rsp_sel       = rsp_out.tag[`GPU_MTAG_W-1 -: sel_w];
    assign rsp_out.ready = rsp_ready[rsp_sel];

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/gpu_pkg.sv
source/gpu_ifs.sv
source/dcr_data.sv
source/compute_cluster.sv
source/mem_mux.sv
source/gpu_top.sv
tb/tb_mem_model.sv
tb/tb_gpu_top.sv

// File: tb/tb_gpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module tb_gpu_top;
    import gpu_pkg::*;

    localparam logic [31:0] seed       = 32'h6bc4_b7d3;
    localparam int          max_cycles = 4000;  // four runs of about 600 cycles at worst
    localparam int          run_len    = `GPU_NUM_CLUSTERS * `GPU_SLICE_LEN;
    localparam mem_addr_t   src_base   = 16'h1000;
    localparam mem_addr_t   dst_base   = 16'h8000;

    logic      clk;
    logic      arst_n;
    logic      stall_en;
    logic      mem_req_valid;
    logic      mem_req_rw;
    mem_addr_t mem_req_addr;
    mem_data_t mem_req_data;
    mtag_t     mem_req_tag;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    mem_data_t mem_rsp_data;
    mtag_t     mem_rsp_tag;
    logic      mem_rsp_ready;
    logic      dcr_wr_valid;
    dcr_addr_t dcr_wr_addr;
    mem_data_t dcr_wr_data;
    logic      dcr_wr_ready;
    logic      start;
    logic      busy;

    int        errors = 0;
    int        tests_pass = 0;
    int        tests_fail = 0;
    int        cycles = 0;
    int        wr_seen [run_len];
    mem_addr_t cur_src = src_base;
    mem_addr_t cur_dst = dst_base;
    logic [$clog2(run_len)-1:0] wr_off;

    gpu_top DUT (.*);

    tb_mem_model #(.seed(seed)) u_mem (
        .clk (clk), .arst_n (arst_n), .stall_en (stall_en),
        .req_valid (mem_req_valid), .req_rw (mem_req_rw), .req_addr (mem_req_addr),
        .req_data (mem_req_data), .req_tag (mem_req_tag), .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid), .rsp_data (mem_rsp_data), .rsp_tag (mem_rsp_tag),
        .rsp_ready (mem_rsp_ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_pass++;
            $display("test %s: ok", name);
        end else begin
            tests_fail++;
            $display("test %s: %0d error(s)", name, errors - err_mark);
        end
    endtask

    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_rw)
            && $stable(mem_req_addr) && $stable(mem_req_data) && $stable(mem_req_tag))
        else flag_error("request fields changed under back-pressure");
    cfg_lock: assert property (@(posedge clk) disable iff (!arst_n) busy |-> !dcr_wr_ready)
        else flag_error("dcr_wr_ready high while busy");
    wr_range: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && mem_req_ready && mem_req_rw
            |-> mem_addr_t'(mem_req_addr - cur_dst) < mem_addr_t'(run_len))
        else flag_error("write outside the destination range");
    // cluster select and element index are the low bits of the offset
    tag_map: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid
            |-> mem_req_tag == mtag_t'(mem_req_addr - (mem_req_rw ? cur_dst : cur_src)))
        else flag_error("request tag does not match the element offset");
    req_busy: assert property (@(posedge clk) disable iff (!arst_n) mem_req_valid |-> busy)
        else flag_error("memory request while not busy");
    busy_rise: assert property (@(posedge clk) disable iff (!arst_n) start && !busy |=> busy)
        else flag_error("busy did not rise after start");

    // accepted writes per destination word
    always @(negedge clk) begin
        if (arst_n && mem_req_valid && mem_req_ready && mem_req_rw) begin
            if (mem_addr_t'(mem_req_addr - cur_dst) < mem_addr_t'(run_len)) begin
                wr_off = ($clog2(run_len))'(mem_req_addr - cur_dst);
                wr_seen[wr_off]++;
            end
        end
    end

    task automatic dcr_write(input dcr_addr_t addr, input mem_data_t data);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
        @(negedge clk);
        while (!dcr_wr_ready) @(negedge clk);
        @(posedge clk);
        #2;
        dcr_wr_valid = 1'b0;
    endtask

    task automatic configure(input mem_addr_t src, input mem_addr_t dst, input mem_data_t add);
        dcr_write(dcr_addr_t'(`GPU_DCR_SRC), mem_data_t'(src));
        dcr_write(dcr_addr_t'(`GPU_DCR_DST), mem_data_t'(dst));
        dcr_write(dcr_addr_t'(`GPU_DCR_ADD), add);
    endtask

    task automatic run_job(input mem_addr_t src, input mem_addr_t dst, input mem_data_t add,
                           input logic probe_lock);
        mem_data_t expect_w [run_len];
        for (int k = 0; k < run_len; k++) begin
            expect_w[k] = u_mem.mem[mem_addr_t'(src + k)] + add;  // wraps mod 2^32
            wr_seen[k]  = 0;
        end
        cur_src = src;
        cur_dst = dst;
        start   = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (probe_lock) begin
            repeat (3) @(posedge clk);
            #2;
            dcr_wr_valid = 1'b1;   // must bounce off the lock
            dcr_wr_addr  = dcr_addr_t'(`GPU_DCR_ADD);
            dcr_wr_data  = ~add;
            repeat (4) @(posedge clk);
            #2;
            dcr_wr_valid = 1'b0;
        end
        while (busy) @(negedge clk);
        for (int k = 0; k < run_len; k++) begin
            assert (u_mem.mem[mem_addr_t'(dst + k)] == expect_w[k])
                else flag_error($sformatf("word %0d is %h, expected %h", k,
                                          u_mem.mem[mem_addr_t'(dst + k)], expect_w[k]));
            assert (wr_seen[k] == 1)
                else flag_error($sformatf("word %0d written %0d times", k, wr_seen[k]));
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        int err_mark;
        arst_n       = 1'b0;
        stall_en     = 1'b0;
        start        = 1'b0;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;

        err_mark = errors;
        @(negedge clk);
        assert (!busy) else flag_error("busy high after reset");
        assert (!mem_req_valid) else flag_error("mem_req_valid high after reset");
        assert (dcr_wr_ready) else flag_error("dcr_wr_ready low after reset");
        assert (mem_rsp_ready) else flag_error("mem_rsp_ready low after reset");
        @(posedge clk);
        #2;
        end_test("reset_state", err_mark);

        err_mark = errors;
        configure(src_base, dst_base, 32'h0000_1234);
        run_job(src_base, dst_base, 32'h0000_1234, 1'b0);
        end_test("compute", err_mark);

        err_mark = errors;
        stall_en = 1'b1;
        configure(src_base, dst_base + 16'h0100, 32'hffff_fff0);
        run_job(src_base, dst_base + 16'h0100, 32'hffff_fff0, 1'b0);
        end_test("back_pressure", err_mark);

        err_mark = errors;
        configure(src_base, dst_base + 16'h0200, 32'h0bad_0001);
        run_job(src_base, dst_base + 16'h0200, 32'h0bad_0001, 1'b1);
        dcr_write(dcr_addr_t'(`GPU_DCR_ADD), 32'h7000_0007);  // new addend for the rerun
        run_job(src_base, dst_base + 16'h0200, 32'h7000_0007, 1'b0);
        end_test("config_lock", err_mark);

        $display("tests passed: %0d, failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpu_consts.svh"

module tb_mem_model #(
    parameter logic [31:0] seed = 32'h1
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     stall_en,
    input  wire                     req_valid,
    input  wire                     req_rw,
    input  wire gpu_pkg::mem_addr_t req_addr,
    input  wire gpu_pkg::mem_data_t req_data,
    input  wire gpu_pkg::mtag_t     req_tag,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output gpu_pkg::mem_data_t      rsp_data,
    output gpu_pkg::mtag_t          rsp_tag,
    input  wire                     rsp_ready
);
    import gpu_pkg::*;

    mem_data_t   mem [0:65535];
    mem_data_t   q_data [$];    // pending reads, oldest first
    mtag_t       q_tag [$];
    int unsigned q_due [$];
    int unsigned cycle;
    logic        req_fire;
    logic        rsp_fire;
    logic        f_rw;
    mem_addr_t   f_addr;
    mem_data_t   f_data;
    mtag_t       f_tag;

    initial begin
        void'($urandom(seed));
        for (int a = 0; a < 65536; a++) begin
            mem[a] = $urandom;
        end
        cycle     = 0;
        req_ready = 1'b1;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        rsp_tag   = '0;
        forever begin
            @(negedge clk);
            req_fire = req_valid && req_ready;  // stable until the edge
            rsp_fire = rsp_valid && rsp_ready;
            f_rw     = req_rw;
            f_addr   = req_addr;
            f_data   = req_data;
            f_tag    = req_tag;
            @(posedge clk);
            #2;
            cycle++;
            if (!arst_n) begin
                q_data.delete();
                q_tag.delete();
                q_due.delete();
            end else begin
                if (rsp_fire) begin
                    void'(q_data.pop_front());
                    void'(q_tag.pop_front());
                    void'(q_due.pop_front());
                end
                if (req_fire && f_rw) begin
                    mem[f_addr] = f_data;
                end else if (req_fire) begin
                    q_data.push_back(mem[f_addr]);
                    q_tag.push_back(f_tag);
                    q_due.push_back(cycle + 1 + ($urandom % 4));  // 1 to 4 cycles
                end
            end
            rsp_valid = (q_due.size() != 0) && (q_due[0] <= cycle);
            if (q_data.size() != 0) begin
                rsp_data = q_data[0];
                rsp_tag  = q_tag[0];
            end
            req_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
        end
    end

endmodule

`default_nettype wire
